//--- source/img_stream_pkg.sv
package img_stream_pkg;

   // item type tag carried next to every 16-bit input item
   localparam int DTYPE_WIDTH = 4;

   // raw sensor item width
   localparam int PIX_WIDTH = 16;

   // packed output word width, two pixels
   localparam int WORD_WIDTH = 32;

   // markers use low codes
   // the pixel code sits alone in the top bit, so a mask test also works
   typedef enum logic [DTYPE_WIDTH-1:0] {
      DT_IDLE        = 4'h0,
      DT_FRAME_START = 4'h1,
      DT_FRAME_END   = 4'h2,
      DT_LINE_START  = 4'h3,
      DT_LINE_END    = 4'h4,
      DT_PIXEL       = 4'h8
   } dtype_t;

endpackage

//--- source/term_regs_pkg.sv
package term_regs_pkg;

   // width of the terminal select bus
   localparam int TERM_ADDR_WIDTH = 16;

   // register address bus width
   localparam int REG_ADDR_WIDTH = 32;

   // register data bus width, both directions
   localparam int REG_DATA_WIDTH = 32;

   // default terminal address of the packer
   localparam logic [TERM_ADDR_WIDTH-1:0] TERM_RAW_TO_32 = 16'h0020;

   // register map of the packer terminal
   // control is read/write with pack in bit 0
   // id is read-only
   typedef enum logic [REG_ADDR_WIDTH-1:0] {
      REG_CONTROL = 32'd0,
      REG_ID      = 32'd1
   } reg_addr_t;

endpackage

//--- source/pack_config_regs.sv
module pack_config_regs #(
   parameter logic [term_regs_pkg::TERM_ADDR_WIDTH-1:0] TERM_ADDR =
      term_regs_pkg::TERM_RAW_TO_32,
   parameter logic [term_regs_pkg::REG_DATA_WIDTH-1:0]  ID_VALUE  = '0
) (
   input  logic                                       di_clk,
   input  logic                                       arst_n,
   input  logic [term_regs_pkg::TERM_ADDR_WIDTH-1:0]  di_term_addr,
   input  logic [term_regs_pkg::REG_ADDR_WIDTH-1:0]   di_reg_addr,
   input  logic                                       di_read,
   input  logic                                       di_write,
   input  logic [term_regs_pkg::REG_DATA_WIDTH-1:0]   di_reg_datai,
   output logic                                       di_en,
   output logic [term_regs_pkg::REG_DATA_WIDTH-1:0]   di_reg_datao,
   output logic                                       pack_req
);

   // read mux output, registered on a read strobe
   logic [term_regs_pkg::REG_DATA_WIDTH-1:0] rd_data;

   // strobes qualified by our own terminal select
   logic wr_hit;
   logic rd_hit;

   // terminal select, purely combinational
   assign di_en  = (di_term_addr == TERM_ADDR);
   assign wr_hit = di_write && di_en;
   assign rd_hit = di_read && di_en;

   // control register, only bit 0 is implemented
   always_ff @(posedge di_clk or negedge arst_n) begin
      if (!arst_n) begin
         pack_req <= 1'b0;
      end else if (wr_hit && (di_reg_addr == term_regs_pkg::REG_CONTROL)) begin
         pack_req <= di_reg_datai[0];
      end
   end

   // register map decode
   // unmapped addresses return zero
   always_comb begin
      rd_data = '0;
      case (di_reg_addr)
         term_regs_pkg::REG_CONTROL: begin
            rd_data[0] = pack_req;
         end
         term_regs_pkg::REG_ID: begin
            rd_data = ID_VALUE;
         end
         default: begin
            rd_data = '0;
         end
      endcase
   end

   // read data valid one cycle after the strobe
   // held until the next read to this terminal
   always_ff @(posedge di_clk or negedge arst_n) begin
      if (!arst_n) begin
         di_reg_datao <= '0;
      end else if (rd_hit) begin
         di_reg_datao <= rd_data;
      end
   end

   // host never reads and writes the same terminal in one cycle
   a_no_rd_wr_overlap: assert property (
      @(posedge di_clk) disable iff (!arst_n)
      di_en |-> !(di_read && di_write)
   ) else $error("read and write strobes overlap on the packer terminal");

endmodule

//--- source/stream_input_stage.sv
module stream_input_stage (
   input  logic                                   img_clk,
   input  logic                                   arst_n,
   input  logic                                   pack_req,
   input  logic                                   dvi,
   input  img_stream_pkg::dtype_t                 dtypei,
   input  logic [img_stream_pkg::PIX_WIDTH-1:0]   datai,
   output logic                                   s1_valid,
   output img_stream_pkg::dtype_t                 s1_dtype,
   output logic [img_stream_pkg::PIX_WIDTH-1:0]   s1_data,
   output logic                                   frame_pack
);

   // two flop synchronizer for the di_clk control bit
   logic pack_meta;
   logic pack_sync;

   // frame start seen on the input this cycle
   logic sof_in;

   assign sof_in = dvi && (dtypei == img_stream_pkg::DT_FRAME_START);

   always_ff @(posedge img_clk or negedge arst_n) begin
      if (!arst_n) begin
         pack_meta <= 1'b0;
         pack_sync <= 1'b0;
      end else begin
         pack_meta <= pack_req;
         pack_sync <= pack_meta;
      end
   end

   // mode is sampled only at a frame start
   // changes mid frame wait for the next frame
   always_ff @(posedge img_clk or negedge arst_n) begin
      if (!arst_n) begin
         frame_pack <= 1'b0;
      end else if (sof_in) begin
         frame_pack <= pack_sync;
      end
   end

   // valid strobe, one cycle behind dvi
   always_ff @(posedge img_clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= dvi;
      end
   end

   // payload, only captured on an accepted item
   always_ff @(posedge img_clk) begin
      if (dvi) begin
         s1_dtype <= dtypei;
         s1_data  <= datai;
      end
   end

   // idle tag never arrives as a valid item
   a_no_idle_item: assert property (
      @(posedge img_clk) disable iff (!arst_n)
      dvi |-> (dtypei != img_stream_pkg::DT_IDLE)
   ) else $error("valid input item tagged as idle");

endmodule

//--- source/raw_to_32.sv
module raw_to_32 (
   input  logic                                   img_clk,
   input  logic                                   arst_n,
   input  logic                                   s1_valid,
   input  img_stream_pkg::dtype_t                 s1_dtype,
   input  logic [img_stream_pkg::PIX_WIDTH-1:0]   s1_data,
   input  logic                                   frame_pack,
   output logic                                   dvo,
   output img_stream_pkg::dtype_t                 dtypeo,
   output logic [img_stream_pkg::WORD_WIDTH-1:0]  datao
);

   localparam int PW = img_stream_pkg::PIX_WIDTH;

   typedef enum logic {
      PAIR_EMPTY,
      PAIR_HALF
   } pair_state_t;

   // pairing state and the held low pixel
   pair_state_t   pair_q;
   pair_state_t   pair_nxt;
   logic [PW-1:0] held_q;
   logic [PW-1:0] held_nxt;

   // one entry slot, delays a single word item behind a flush
   logic                   slot_full_q;
   logic                   slot_full_nxt;
   img_stream_pkg::dtype_t slot_dtype_q;
   img_stream_pkg::dtype_t slot_dtype_nxt;
   logic [PW-1:0]          slot_data_q;
   logic [PW-1:0]          slot_data_nxt;

   // word selected for the output register this cycle
   logic                                  out_v;
   img_stream_pkg::dtype_t                out_dtype;
   logic [img_stream_pkg::WORD_WIDTH-1:0] out_data;

   // slot traffic, also seen by the assertions
   logic slot_load;
   logic slot_emit;

   logic in_pixel;

   assign in_pixel = (s1_dtype == img_stream_pkg::DT_PIXEL);

   always_comb begin
      pair_nxt       = pair_q;
      held_nxt       = held_q;
      slot_full_nxt  = slot_full_q;
      slot_dtype_nxt = slot_dtype_q;
      slot_data_nxt  = slot_data_q;
      out_v          = 1'b0;
      out_dtype      = slot_dtype_q;
      out_data       = {{PW{1'b0}}, slot_data_q};
      slot_load      = 1'b0;
      slot_emit      = 1'b0;
      if (s1_valid) begin
         if (pair_q == PAIR_HALF) begin
            // slot is always empty here
            out_v     = 1'b1;
            out_dtype = img_stream_pkg::DT_PIXEL;
            pair_nxt  = PAIR_EMPTY;
            if (in_pixel) begin
               // second pixel goes high, held one low
               out_data = {s1_data, held_q};
            end else begin
               // odd pixel flushed alone, marker waits in the slot
               out_data  = {{PW{1'b0}}, held_q};
               slot_load = 1'b1;
            end
         end else if (frame_pack && in_pixel) begin
            // first of a pair, no word from the input
            // so a waiting slot gets the output
            held_nxt = s1_data;
            pair_nxt = PAIR_HALF;
            if (slot_full_q) begin
               out_v         = 1'b1;
               slot_emit     = 1'b1;
               slot_full_nxt = 1'b0;
            end
         end else if (slot_full_q) begin
            // slot goes first, new item queues behind it
            out_v     = 1'b1;
            slot_emit = 1'b1;
            slot_load = 1'b1;
         end else begin
            // plain pass through with zero upper half
            out_v     = 1'b1;
            out_dtype = s1_dtype;
            out_data  = {{PW{1'b0}}, s1_data};
         end
      end else if (slot_full_q) begin
         // gap in the stream drains the slot
         out_v         = 1'b1;
         slot_emit     = 1'b1;
         slot_full_nxt = 1'b0;
      end
      if (slot_load) begin
         slot_full_nxt  = 1'b1;
         slot_dtype_nxt = s1_dtype;
         slot_data_nxt  = s1_data;
      end
   end

   always_ff @(posedge img_clk or negedge arst_n) begin
      if (!arst_n) begin
         pair_q      <= PAIR_EMPTY;
         slot_full_q <= 1'b0;
         dvo         <= 1'b0;
      end else begin
         pair_q      <= pair_nxt;
         slot_full_q <= slot_full_nxt;
         dvo         <= out_v;
      end
   end

   // data path registers
   always_ff @(posedge img_clk) begin
      held_q       <= held_nxt;
      slot_dtype_q <= slot_dtype_nxt;
      slot_data_q  <= slot_data_nxt;
      if (out_v) begin
         dtypeo <= out_dtype;
         datao  <= out_data;
      end
   end

   // credit check, a full slot is always drained before it is refilled
   a_slot_no_overwrite: assert property (
      @(posedge img_clk) disable iff (!arst_n)
      (slot_load && slot_full_q) |-> slot_emit
   ) else $error("marker slot overwritten without emitting its entry");

   // a half pair only exists inside a packed frame
   a_half_only_packed: assert property (
      @(posedge img_clk) disable iff (!arst_n)
      (pair_q == PAIR_HALF) |-> frame_pack
   ) else $error("pixel held while the frame is not in pack mode");

endmodule

//--- source/raw_to_32_top.sv
module raw_to_32_top #(
   parameter logic [term_regs_pkg::TERM_ADDR_WIDTH-1:0] TERM_ADDR =
      term_regs_pkg::TERM_RAW_TO_32,
   parameter logic [term_regs_pkg::REG_DATA_WIDTH-1:0]  ID_VALUE  = 32'h5232_0100
) (
   input  logic                                       di_clk,
   input  logic                                       img_clk,
   input  logic                                       arst_n,
   input  logic [term_regs_pkg::TERM_ADDR_WIDTH-1:0]  di_term_addr,
   input  logic [term_regs_pkg::REG_ADDR_WIDTH-1:0]   di_reg_addr,
   input  logic                                       di_read,
   input  logic                                       di_write,
   input  logic [term_regs_pkg::REG_DATA_WIDTH-1:0]   di_reg_datai,
   input  logic                                       dvi,
   input  img_stream_pkg::dtype_t                     dtypei,
   input  logic [img_stream_pkg::PIX_WIDTH-1:0]       datai,
   output logic                                       di_en,
   output logic [term_regs_pkg::REG_DATA_WIDTH-1:0]   di_reg_datao,
   output logic                                       dvo,
   output img_stream_pkg::dtype_t                     dtypeo,
   output logic [img_stream_pkg::WORD_WIDTH-1:0]      datao
);

   // pack bit, still in the di_clk domain
   logic pack_req;

   // first stage to packer
   logic                                 s1_valid;
   img_stream_pkg::dtype_t               s1_dtype;
   logic [img_stream_pkg::PIX_WIDTH-1:0] s1_data;
   logic                                 frame_pack;

   pack_config_regs #(
      .TERM_ADDR (TERM_ADDR),
      .ID_VALUE  (ID_VALUE)
   ) i_pack_config_regs (
      .di_clk       (di_clk),
      .arst_n       (arst_n),
      .di_term_addr (di_term_addr),
      .di_reg_addr  (di_reg_addr),
      .di_read      (di_read),
      .di_write     (di_write),
      .di_reg_datai (di_reg_datai),
      .di_en        (di_en),
      .di_reg_datao (di_reg_datao),
      .pack_req     (pack_req)
   );

   // crosses pack_req into img_clk
   stream_input_stage i_stream_input_stage (
      .img_clk    (img_clk),
      .arst_n     (arst_n),
      .pack_req   (pack_req),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .datai      (datai),
      .s1_valid   (s1_valid),
      .s1_dtype   (s1_dtype),
      .s1_data    (s1_data),
      .frame_pack (frame_pack)
   );

   raw_to_32 i_raw_to_32 (
      .img_clk    (img_clk),
      .arst_n     (arst_n),
      .s1_valid   (s1_valid),
      .s1_dtype   (s1_dtype),
      .s1_data    (s1_data),
      .frame_pack (frame_pack),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .datao      (datao)
   );

endmodule

//--- tb/stream_model.svh
`ifndef STREAM_MODEL_SVH
`define STREAM_MODEL_SVH

// expected output words and tags, in output order
logic [img_stream_pkg::WORD_WIDTH-1:0] exp_word[$];
img_stream_pkg::dtype_t                exp_dtype[$];

// mode latched at the last frame start
logic                                  model_pack;

// low pixel waiting for its partner
logic                                  model_held_v;
logic [img_stream_pkg::PIX_WIDTH-1:0]  model_held;

task automatic model_expect(input logic [img_stream_pkg::WORD_WIDTH-1:0] word,
                            input img_stream_pkg::dtype_t dtype);
   exp_word.push_back(word);
   exp_dtype.push_back(dtype);
endtask

// one accepted input item, mode_now is the control bit in force
task automatic model_apply(input img_stream_pkg::dtype_t dtype,
                           input logic [img_stream_pkg::PIX_WIDTH-1:0] data,
                           input logic mode_now);
   if (dtype == img_stream_pkg::DT_FRAME_START) begin
      model_pack = mode_now;
   end
   if (dtype == img_stream_pkg::DT_PIXEL && model_pack) begin
      if (model_held_v) begin
         // second pixel in the upper half
         model_expect({data, model_held}, img_stream_pkg::DT_PIXEL);
         model_held_v = 1'b0;
      end else begin
         model_held_v = 1'b1;
         model_held   = data;
      end
   end else begin
      // odd pixel leaves alone, ahead of the marker
      if (model_held_v) begin
         model_expect({{img_stream_pkg::PIX_WIDTH{1'b0}}, model_held},
                      img_stream_pkg::DT_PIXEL);
         model_held_v = 1'b0;
      end
      model_expect({{img_stream_pkg::PIX_WIDTH{1'b0}}, data}, dtype);
   end
endtask

`endif

//--- tb/raw_to_32_tb.sv
module raw_to_32_tb;

   localparam logic [term_regs_pkg::TERM_ADDR_WIDTH-1:0] TERM = term_regs_pkg::TERM_RAW_TO_32;
   localparam logic [term_regs_pkg::REG_DATA_WIDTH-1:0]  ID_VAL = 32'h5232_0100;
   localparam int NUM_FRAMES = 8;

   logic di_clk;
   logic img_clk;
   logic arst_n;
   logic [term_regs_pkg::TERM_ADDR_WIDTH-1:0] di_term_addr;
   logic [term_regs_pkg::REG_ADDR_WIDTH-1:0]  di_reg_addr;
   logic di_read;
   logic di_write;
   logic [term_regs_pkg::REG_DATA_WIDTH-1:0]  di_reg_datai;
   logic dvi;
   img_stream_pkg::dtype_t dtypei;
   logic [img_stream_pkg::PIX_WIDTH-1:0] datai;
   logic di_en;
   logic [term_regs_pkg::REG_DATA_WIDTH-1:0]  di_reg_datao;
   logic dvo;
   img_stream_pkg::dtype_t dtypeo;
   logic [img_stream_pkg::WORD_WIDTH-1:0] datao;

   // pre-built stimulus
   // wr holds -1 or a control value written before the item
   img_stream_pkg::dtype_t q_dtype[$];
   logic [img_stream_pkg::PIX_WIDTH-1:0] q_data[$];
   int q_gap[$];
   int q_wr[$];
   int stim_count;
   logic tb_mode;

   `include "stream_model.svh"

   raw_to_32_top #(
      .TERM_ADDR (TERM),
      .ID_VALUE  (ID_VAL)
   ) i_raw_to_32_top (
      .di_clk       (di_clk),
      .img_clk      (img_clk),
      .arst_n       (arst_n),
      .di_term_addr (di_term_addr),
      .di_reg_addr  (di_reg_addr),
      .di_read      (di_read),
      .di_write     (di_write),
      .di_reg_datai (di_reg_datai),
      .dvi          (dvi),
      .dtypei       (dtypei),
      .datai        (datai),
      .di_en        (di_en),
      .di_reg_datao (di_reg_datao),
      .dvo          (dvo),
      .dtypeo       (dtypeo),
      .datao        (datao)
   );

   initial begin
      img_clk = 1'b0;
      forever #50 img_clk = ~img_clk;
   end

   // same period shifted by 30
   initial begin
      di_clk = 1'b0;
      #30;
      forever #50 di_clk = ~di_clk;
   end

   task automatic abort_run();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input logic [img_stream_pkg::WORD_WIDTH-1:0] act,
                             input logic [img_stream_pkg::WORD_WIDTH-1:0] exp);
      if (act !== exp) begin
         $display("CHECK FAILED datao actual %h expected %h", act, exp);
         abort_run();
      end
   endtask

   task automatic check_dtype(input img_stream_pkg::dtype_t act,
                              input img_stream_pkg::dtype_t exp);
      if (act !== exp) begin
         $display("CHECK FAILED dtypeo actual %h expected %h", act, exp);
         abort_run();
      end
   endtask

   task automatic check_reg(input logic [term_regs_pkg::REG_DATA_WIDTH-1:0] act,
                            input logic [term_regs_pkg::REG_DATA_WIDTH-1:0] exp);
      if (act !== exp) begin
         $display("CHECK FAILED di_reg_datao actual %h expected %h", act, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("CHECK FAILED %s actual %h expected %h", name, act, exp);
         abort_run();
      end
   endtask

   function automatic logic [term_regs_pkg::REG_DATA_WIDTH-1:0] ctrl_value(input logic pack);
      return {{(term_regs_pkg::REG_DATA_WIDTH-1){1'b0}}, pack};
   endfunction

   // one strobe cycle
   // di_en checked while the strobe is up
   task automatic reg_access(input logic [term_regs_pkg::TERM_ADDR_WIDTH-1:0] term,
                             input logic [term_regs_pkg::REG_ADDR_WIDTH-1:0] addr,
                             input logic wr,
                             input logic [term_regs_pkg::REG_DATA_WIDTH-1:0] wdata,
                             input logic exp_en);
      @(negedge di_clk);
      di_term_addr = term;
      di_reg_addr  = addr;
      di_write     = wr;
      di_read      = !wr;
      di_reg_datai = wdata;
      @(posedge di_clk);
      check_flag("di_en", di_en, exp_en);
      @(negedge di_clk);
      di_write = 1'b0;
      di_read  = 1'b0;
   endtask

   task automatic reg_read_check(input logic [term_regs_pkg::REG_ADDR_WIDTH-1:0] addr,
                                 input logic [term_regs_pkg::REG_DATA_WIDTH-1:0] exp);
      reg_access(TERM, addr, 1'b0, '0, 1'b1);
      check_reg(di_reg_datao, exp);
   endtask

   task automatic add_item(input img_stream_pkg::dtype_t dtype, input int gap, input int wr);
      q_dtype.push_back(dtype);
      q_data.push_back(img_stream_pkg::PIX_WIDTH'($urandom()));
      q_gap.push_back(gap);
      q_wr.push_back(wr);
   endtask

   // random frames
   // a mode flip lands mid frame in every odd frame
   task automatic build_stimulus();
      int nl;
      int np;
      int gen_mode;
      gen_mode = 0;
      for (int f = 0; f < NUM_FRAMES; f++) begin
         // long gap before frame start lets the synchronizer settle
         add_item(img_stream_pkg::DT_FRAME_START, 4 + int'($urandom() % 3), -1);
         nl = 2 + int'($urandom() % 4);
         for (int l = 0; l < nl; l++) begin
            if (l == 1 && f % 2 == 1) begin
               gen_mode = 1 - gen_mode;
               add_item(img_stream_pkg::DT_LINE_START, 0, gen_mode);
            end else begin
               add_item(img_stream_pkg::DT_LINE_START, 0, -1);
            end
            np = 1 + int'($urandom() % 9);
            for (int p = 0; p < np; p++) begin
               add_item(img_stream_pkg::DT_PIXEL, int'($urandom() % 3), -1);
            end
            add_item(img_stream_pkg::DT_LINE_END, 0, -1);
         end
         add_item(img_stream_pkg::DT_FRAME_END, 0, -1);
      end
      stim_count = q_dtype.size();
   endtask

   // output side sampled away from the rising edge
   initial begin
      forever begin
         @(negedge img_clk);
         if (arst_n && dvo) begin
            if (exp_word.size() == 0) begin
               $display("output word appeared with no expected item");
               abort_run();
            end else begin
               check_word(datao, exp_word.pop_front());
               check_dtype(dtypeo, exp_dtype.pop_front());
            end
         end
      end
   end

   // limit from the stimulus length
   initial begin
      wait (stim_count != 0);
      repeat (stim_count * 4 + 2000) @(posedge img_clk);
      $display("watchdog expired before the stream finished");
      abort_run();
   end

   initial begin
      int drain;
      arst_n       = 1'b0;
      di_term_addr = '0;
      di_reg_addr  = '0;
      di_read      = 1'b0;
      di_write     = 1'b0;
      di_reg_datai = '0;
      dvi          = 1'b0;
      dtypei       = img_stream_pkg::DT_IDLE;
      datai        = '0;
      tb_mode      = 1'b0;
      model_pack   = 1'b0;
      model_held_v = 1'b0;
      model_held   = '0;
      stim_count   = 0;
      void'($urandom(73));
      build_stimulus();
      repeat (10) @(negedge img_clk);
      arst_n = 1'b1;

      // register terminal
      reg_read_check(term_regs_pkg::REG_ID, ID_VAL);
      reg_access(TERM, term_regs_pkg::REG_CONTROL, 1'b1, ctrl_value(1'b1), 1'b1);
      reg_read_check(term_regs_pkg::REG_CONTROL, ctrl_value(1'b1));
      // foreign terminal must not write
      reg_access(TERM ^ 16'h0001, term_regs_pkg::REG_CONTROL, 1'b1, ctrl_value(1'b0), 1'b0);
      reg_read_check(term_regs_pkg::REG_CONTROL, ctrl_value(1'b1));
      reg_read_check(32'd7, '0);
      reg_access(TERM, term_regs_pkg::REG_CONTROL, 1'b1, ctrl_value(1'b0), 1'b1);
      reg_read_check(term_regs_pkg::REG_CONTROL, ctrl_value(1'b0));
      // foreign read keeps the old read data
      reg_access(TERM ^ 16'h0100, term_regs_pkg::REG_ID, 1'b0, '0, 1'b0);
      check_reg(di_reg_datao, ctrl_value(1'b0));

      // image stream
      for (int i = 0; i < stim_count; i++) begin
         if (q_wr[i] >= 0) begin
            @(negedge img_clk);
            dvi     = 1'b0;
            tb_mode = (q_wr[i] != 0);
            reg_access(TERM, term_regs_pkg::REG_CONTROL, 1'b1, ctrl_value(tb_mode), 1'b1);
            reg_read_check(term_regs_pkg::REG_CONTROL, ctrl_value(tb_mode));
         end
         repeat (q_gap[i]) begin
            @(negedge img_clk);
            dvi = 1'b0;
         end
         @(negedge img_clk);
         dvi    = 1'b1;
         dtypei = q_dtype[i];
         datai  = q_data[i];
         model_apply(q_dtype[i], q_data[i], tb_mode);
      end
      @(negedge img_clk);
      dvi    = 1'b0;
      dtypei = img_stream_pkg::DT_IDLE;

      // drain and then watch for stray words
      drain = 0;
      while (exp_word.size() != 0 && drain < 50) begin
         @(negedge img_clk);
         drain++;
      end
      repeat (10) @(negedge img_clk);
      if (exp_word.size() != 0) begin
         $display("%0d expected words never appeared on the output", exp_word.size());
         abort_run();
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

//--- list.f
source/img_stream_pkg.sv
source/term_regs_pkg.sv
source/pack_config_regs.sv
source/stream_input_stage.sv
source/raw_to_32.sv
source/raw_to_32_top.sv
+incdir+tb
tb/raw_to_32_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the packer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f list.f --top-module raw_to_32_tb -o raw_to_32_sim

./obj_dir/raw_to_32_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
